//--- all.f
src/loader_pkg.sv
src/loader_fsm.sv
src/halfword_packer.sv
src/word_counter.sv
src/backup_control.sv
src/loader_top.sv
test/loader_tb_assert.sv
test/loader_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = loader_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, then check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/loader_tb.sv
module loader_tb
	import loader_pkg::*;
();

	typedef enum logic [2:0] {
		rk_start,
		rk_end,
		rk_write,
		rk_backup,
		rk_check
	} row_kind_t;

	// Column use depends on the row kind
	typedef struct packed {
		row_kind_t  kind;
		logic [7:0] index;
		dl_addr_t   addr;
		word_t      data;
		word_t      exp_word;
		ram_addr_t  exp_addr;
	} row_t;

	logic        clk_1x = 1'b0;
	logic        arst_n;
	dl_in_t      dl;
	logic        ram_ready = 1'b0;
	logic        img_mounted;
	logic        img_readonly;
	word_t       img_size;
	logic        load_menu;
	logic        save_menu;
	logic        osd_status;
	logic        autosave_off;
	logic        ioctl_wait;
	pif_wr_t     pif_wr;
	ram_req_t    ram_req;
	cart_count_t cart_words;
	logic        cart_loaded;
	logic        use_img;
	logic        bk_load;
	logic        bk_save;

	row_t        rows[$];
	word_t       sent_data[$];
	ram_addr_t   sent_addr[$];
	word_t       got_data[$];
	ram_addr_t   got_addr[$];
	logic [7:0]  cur_index;
	integer      seed = 32'hef028797;
	int          cycles = 0;
	int          timeout_limit;
	int          pif_sent;
	int          pif_seen = 0;

	loader_top i_loader_top (.*);

	bind loader_top loader_tb_assert i_loader_tb_assert (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.ioctl_wait (ioctl_wait),
		.pif_wr     (pif_wr),
		.ram_req    (ram_req)
	);

	always #2 clk_1x = ~clk_1x;

	always @(posedge clk_1x) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped handshaking", cycles);
			$display("STATUS: FAIL");
			$fatal(1, "Simulation timed out");
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	task automatic match_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Bit mismatch");
		end
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Value mismatch");
		end
	endtask

	// ==================================================
	// RAM responder and pulse monitor
	// ==================================================

	always begin
		int delay;
		@(negedge clk_1x);
		if (ram_req.req) begin
			got_data.push_back(ram_req.data);
			got_addr.push_back(ram_req.addr);
			delay = 1 + ($unsigned($random(seed)) % 4);
			repeat (delay) begin
				@(posedge clk_1x);
			end
			ram_ready <= 1'b1;
			@(negedge clk_1x);
			match_bit("ioctl_wait", ioctl_wait, 1'b1);
			@(posedge clk_1x);
			ram_ready <= 1'b0;
			// Host released on the edge that took ram_ready
			@(negedge clk_1x);
			match_bit("ioctl_wait", ioctl_wait, 1'b0);
		end
	end

	always @(negedge clk_1x) begin
		if (pif_wr.en) begin
			pif_seen <= pif_seen + 1;
		end
	end

	// ==================================================
	// Host model
	// ==================================================

	task automatic send_half(input dl_addr_t addr, input half_t data);
		@(negedge clk_1x);
		while (ioctl_wait) begin
			@(negedge clk_1x);
		end
		@(posedge clk_1x);
		dl.addr <= addr;
		dl.data <= data;
		dl.wr   <= 1'b1;
		@(posedge clk_1x);
		dl.wr <= 1'b0;
	endtask

	task automatic write_word(input row_t r);
		logic pif_mode;
		logic cart_mode;
		pif_mode  = (cur_index[5:0] == idx_pif);
		cart_mode = (cur_index[5:0] == idx_cart);
		send_half(r.addr, r.data[15:0]);
		@(negedge clk_1x);
		match_bit("pif_wr.en", pif_wr.en, 1'b0);
		match_bit("ram_req.req", ram_req.req, 1'b0);
		send_half(r.addr + 27'd2, r.data[31:16]);
		// Strobes land one cycle after the high half
		@(negedge clk_1x);
		match_bit("pif_wr.en", pif_wr.en, pif_mode);
		match_bit("ram_req.req", ram_req.req, cart_mode);
		match_bit("ioctl_wait", ioctl_wait, cart_mode);
		if (pif_mode) begin
			pif_sent++;
			compare_word("pif_wr.data", pif_wr.data, r.exp_word);
			compare_word("pif_wr.addr", word_t'(pif_wr.addr), word_t'(r.exp_addr[9:0]));
		end
		if (cart_mode) begin
			compare_word("ram_req.data", ram_req.data, r.exp_word);
			compare_word("ram_req.addr", word_t'(ram_req.addr), word_t'(r.exp_addr));
			sent_data.push_back(r.exp_word);
			sent_addr.push_back(r.exp_addr);
		end
	endtask

	task automatic open_download(input logic [7:0] index);
		@(posedge clk_1x);
		dl.download <= 1'b1;
		dl.index    <= index;
		cur_index = index;
		repeat (2) begin
			@(posedge clk_1x);
		end
	endtask

	task automatic close_download();
		@(negedge clk_1x);
		while (ioctl_wait) begin
			@(negedge clk_1x);
		end
		@(posedge clk_1x);
		dl.download <= 1'b0;
		repeat (2) begin
			@(posedge clk_1x);
		end
	endtask

	// Flags in data bits 5:0, image size in the address column
	task automatic apply_backup(input row_t r);
		@(posedge clk_1x);
		img_mounted  <= r.data[0];
		img_readonly <= r.data[1];
		load_menu    <= r.data[2];
		save_menu    <= r.data[3];
		osd_status   <= r.data[4];
		autosave_off <= r.data[5];
		img_size     <= word_t'(r.addr);
		@(posedge clk_1x);
		@(negedge clk_1x);
		match_bit("use_img", use_img, r.exp_word[0]);
		match_bit("bk_load", bk_load, r.exp_word[1]);
		match_bit("bk_save", bk_save, r.exp_word[2]);
	endtask

	task automatic verify_counts(input row_t r);
		@(negedge clk_1x);
		while (ioctl_wait) begin
			@(negedge clk_1x);
		end
		@(negedge clk_1x);
		compare_word("cart_words", word_t'(cart_words), word_t'(r.exp_addr[23:0]));
		match_bit("cart_loaded", cart_loaded, r.exp_word[0]);
		match_bit("use_img", use_img, r.exp_word[1]);
		compare_word("pif_wr pulses", word_t'(pif_seen), word_t'(pif_sent));
		compare_word("ram_req pulses", word_t'(got_data.size()), word_t'(sent_data.size()));
		foreach (sent_data[i]) begin
			compare_word("ram_req.data", got_data[i], sent_data[i]);
			compare_word("ram_req.addr", word_t'(got_addr[i]), word_t'(sent_addr[i]));
		end
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================

	function automatic void add_row(input row_kind_t kind, input logic [7:0] index,
			input dl_addr_t addr, input word_t data, input word_t exp_word,
			input ram_addr_t exp_addr);
		rows.push_back('{kind, index, addr, data, exp_word, exp_addr});
	endfunction

	// Backup expects {save, load, use}, check expects {use, loaded} and the count
	function automatic void fill_table();
		add_row(rk_check,  8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_backup, 8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_backup, 8'h00, 27'h000,  32'h0000_0001, 32'h0000_0000, 27'h0);
		add_row(rk_start,  8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_write,  8'h00, 27'h000,  32'h5678_1234, 32'h3412_7856, 27'h000);
		add_row(rk_write,  8'h00, 27'h404,  32'hc3d4_a1b2, 32'hb2a1_d4c3, 27'h101);
		add_row(rk_end,    8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_start,  8'h40, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_write,  8'h40, 27'h008,  32'h2233_0011, 32'h1100_3322, 27'h202);
		add_row(rk_end,    8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		// Index 2 selects no target
		add_row(rk_start,  8'h02, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_write,  8'h02, 27'h000,  32'hbeef_dead, 32'h0000_0000, 27'h0);
		add_row(rk_end,    8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_backup, 8'h00, 27'h8000, 32'h0000_0001, 32'h0000_0001, 27'h0);
		add_row(rk_backup, 8'h00, 27'h000,  32'h0000_0004, 32'h0000_0003, 27'h0);
		add_row(rk_backup, 8'h00, 27'h000,  32'h0000_0030, 32'h0000_0001, 27'h0);
		add_row(rk_backup, 8'h00, 27'h000,  32'h0000_0010, 32'h0000_0005, 27'h0);
		add_row(rk_backup, 8'h00, 27'h000,  32'h0000_0028, 32'h0000_0005, 27'h0);
		add_row(rk_backup, 8'h00, 27'h100,  32'h0000_0003, 32'h0000_0001, 27'h0);
		// Read-only image, so the new cartridge clears use_img
		add_row(rk_start,  8'h01, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_check,  8'h00, 27'h000,  32'h0000_0000, 32'h0000_0001, 27'h0);
		add_row(rk_backup, 8'h00, 27'h100,  32'h0000_0003, 32'h0000_0002, 27'h0);
		add_row(rk_write,  8'h01, 27'h000,  32'h2222_1111, 32'h2222_1111, 27'h800000);
		add_row(rk_write,  8'h01, 27'h004,  32'h5566_3344, 32'h5566_3344, 27'h800004);
		add_row(rk_write,  8'h01, 27'h008,  32'h99aa_7788, 32'h99aa_7788, 27'h800008);
		add_row(rk_write,  8'h01, 27'h100,  32'hddee_bbcc, 32'hddee_bbcc, 27'h800100);
		add_row(rk_check,  8'h00, 27'h000,  32'h0000_0000, 32'h0000_0001, 27'h4);
		add_row(rk_end,    8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_check,  8'h00, 27'h000,  32'h0000_0000, 32'h0000_0001, 27'h4);
		// Writable image survives the next cartridge start
		add_row(rk_backup, 8'h00, 27'h040,  32'h0000_0001, 32'h0000_0001, 27'h0);
		add_row(rk_start,  8'h41, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_check,  8'h00, 27'h000,  32'h0000_0000, 32'h0000_0003, 27'h0);
		add_row(rk_write,  8'h41, 27'h010,  32'h0304_0102, 32'h0304_0102, 27'h800010);
		add_row(rk_write,  8'h41, 27'h014,  32'hf00d_cafe, 32'hf00d_cafe, 27'h800014);
		add_row(rk_end,    8'h00, 27'h000,  32'h0000_0000, 32'h0000_0000, 27'h0);
		add_row(rk_check,  8'h00, 27'h000,  32'h0000_0000, 32'h0000_0003, 27'h2);
	endfunction

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		arst_n       <= 1'b0;
		dl           <= '0;
		img_mounted  <= 1'b0;
		img_readonly <= 1'b0;
		img_size     <= '0;
		load_menu    <= 1'b0;
		save_menu    <= 1'b0;
		osd_status   <= 1'b0;
		autosave_off <= 1'b0;
		cur_index = '0;
		pif_sent  = 0;
		fill_table();
		timeout_limit = 40 * rows.size() + 16;
		repeat (16) begin
			@(posedge clk_1x);
		end
		arst_n <= 1'b1;
		foreach (rows[i]) begin
			case (rows[i].kind)
				rk_start:  open_download(rows[i].index);
				rk_end:    close_download();
				rk_write:  write_word(rows[i]);
				rk_backup: apply_backup(rows[i]);
				default:   verify_counts(rows[i]);
			endcase
		end
		repeat (4) begin
			@(posedge clk_1x);
		end
		if (i_loader_top.i_loader_tb_assert.fail_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("Handshake assertions failed %0d times",
				i_loader_top.i_loader_tb_assert.fail_count);
			$display("STATUS: FAIL");
			$fatal(1, "Handshake assertion failure");
		end
	end

endmodule

//--- test/loader_tb_assert.sv
module loader_tb_assert
	import loader_pkg::*;
(
	input logic     clk_1x,
	input logic     arst_n,
	input logic     ioctl_wait,
	input pif_wr_t  pif_wr,
	input ram_req_t ram_req
);

	int unsigned fail_count = 0;

	// ==================================================
	// Host and RAM handshakes
	// ==================================================

	// Host must be held while the RAM owns the word
	a_req_holds_host: assert property (
		@(posedge clk_1x) disable iff (!arst_n)
		ram_req.req |=> ioctl_wait
	) else begin
		fail_count++;
		$error("RAM request without a host stall on the next cycle");
	end

	// Boot ROM strobe is a single pulse per word
	a_pif_single_pulse: assert property (
		@(posedge clk_1x) disable iff (!arst_n)
		pif_wr.en |=> !pif_wr.en
	) else begin
		fail_count++;
		$error("Boot ROM write enable held for two cycles");
	end

	a_quiet_in_reset: assert property (
		@(posedge clk_1x)
		!arst_n |-> (!ioctl_wait && !ram_req.req)
	) else begin
		fail_count++;
		$error("Host stall or RAM request active during reset");
	end

endmodule

//--- src/loader_top.sv
module loader_top
	import loader_pkg::*;
(
	input  logic        clk_1x,
	input  logic        arst_n,
	input  dl_in_t      dl,
	input  logic        ram_ready,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  word_t       img_size,
	input  logic        load_menu,
	input  logic        save_menu,
	input  logic        osd_status,
	input  logic        autosave_off,
	output logic        ioctl_wait,
	output pif_wr_t     pif_wr,
	output ram_req_t    ram_req,
	output cart_count_t cart_words,
	output logic        cart_loaded,
	output logic        use_img,
	output logic        bk_load,
	output logic        bk_save
);

	logic        cart_download;
	logic        cart_begin;
	logic        pif_push;
	logic        cart_push;

	// ==================================================
	// Download control and data path
	// ==================================================

	loader_fsm i_loader_fsm (
		.clk_1x        (clk_1x),
		.arst_n        (arst_n),
		.dl            (dl),
		.ram_ready     (ram_ready),
		.state         (),
		.cart_download (cart_download),
		.cart_start    (cart_begin),
		.pif_push      (pif_push),
		.cart_push     (cart_push),
		.ioctl_wait    (ioctl_wait)
	);

	halfword_packer i_halfword_packer (
		.clk_1x    (clk_1x),
		.arst_n    (arst_n),
		.dl        (dl),
		.pif_push  (pif_push),
		.cart_push (cart_push),
		.pif_wr    (pif_wr),
		.ram_req   (ram_req)
	);

	// ==================================================
	// Bookkeeping
	// ==================================================

	word_counter i_word_counter (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.cart_start  (cart_begin),
		.ram_ready   (ram_ready),
		.cart_words  (cart_words),
		.cart_loaded (cart_loaded)
	);

	backup_control i_backup_control (
		.clk_1x        (clk_1x),
		.arst_n        (arst_n),
		.cart_start    (cart_begin),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.load_menu     (load_menu),
		.save_menu     (save_menu),
		.osd_status    (osd_status),
		.autosave_off  (autosave_off),
		.use_img       (use_img),
		.bk_load       (bk_load),
		.bk_save       (bk_save)
	);

endmodule

//--- src/backup_control.sv
module backup_control
	import loader_pkg::*;
(
	input  logic  clk_1x,
	input  logic  arst_n,
	input  logic  cart_start,
	input  logic  cart_download,
	input  logic  img_mounted,
	input  logic  img_readonly,
	input  word_t img_size,
	input  logic  load_menu,
	input  logic  save_menu,
	input  logic  osd_status,
	input  logic  autosave_off,
	output logic  use_img,
	output logic  bk_load,
	output logic  bk_save
);

	logic img_ok;

	// Mounted, writable and not empty
	assign img_ok = img_mounted && (img_size != '0) && !img_readonly;

	// ==================================================
	// Image usable flag
	// ==================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			use_img <= 1'b0;
		end else if (img_ok) begin
			// Set wins over the clear from a new cartridge
			use_img <= 1'b1;
		end else if (cart_start) begin
			use_img <= 1'b0;
		end
	end

	// ==================================================
	// Backup requests
	// ==================================================

	// Reload from menu, or when a cartridge arrives with an image mounted
	assign bk_load = load_menu || (cart_download && img_mounted);

	// Save from menu, or on OSD open unless autosave is off
	assign bk_save = save_menu || (osd_status && !autosave_off);

endmodule

//--- src/word_counter.sv
module word_counter
	import loader_pkg::*;
(
	input  logic        clk_1x,
	input  logic        arst_n,
	input  logic        cart_start,
	input  logic        ram_ready,
	output cart_count_t cart_words,
	output logic        cart_loaded
);

	logic at_max;

	// Count sticks at all ones
	assign at_max = &cart_words;

	// ==================================================
	// Accepted word count
	// ==================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			cart_words <= '0;
		end else if (cart_start) begin
			// New image, count restarts
			cart_words <= '0;
		end else if (ram_ready && !at_max) begin
			cart_words <= cart_words + cart_count_t'(1);
		end
	end

	// ==================================================
	// Loaded flag
	// ==================================================

	// Stays set until the next reset
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			cart_loaded <= 1'b0;
		end else if (cart_start) begin
			cart_loaded <= 1'b1;
		end
	end

endmodule

//--- src/halfword_packer.sv
module halfword_packer
	import loader_pkg::*;
(
	input  logic     clk_1x,
	input  logic     arst_n,
	input  dl_in_t   dl,
	input  logic     pif_push,
	input  logic     cart_push,
	output pif_wr_t  pif_wr,
	output ram_req_t ram_req
);

	pif_addr_t pif_addr;
	word_t     pif_data;
	logic      pif_en;
	ram_addr_t ram_addr;
	word_t     ram_data;
	logic      ram_strobe;

	// Boot ROM expects each halfword with its bytes swapped
	function automatic half_t swap_bytes(input half_t h);
		return {h[7:0], h[15:8]};
	endfunction

	// ==================================================
	// Boot ROM word
	// ==================================================

	always_ff @(posedge clk_1x) begin
		if (pif_push) begin
			if (!dl.addr[1]) begin
				pif_data[31:16] <= swap_bytes(dl.data);
				// Index bit 6 selects the upper ROM half
				pif_addr        <= {dl.index[6], dl.addr[10:2]};
			end else begin
				pif_data[15:0] <= swap_bytes(dl.data);
			end
		end
	end

	// ==================================================
	// Cartridge word
	// ==================================================

	always_ff @(posedge clk_1x) begin
		if (cart_push) begin
			if (!dl.addr[1]) begin
				ram_data[15:0] <= dl.data;
				ram_addr       <= dl.addr + cart_start;
			end else begin
				ram_data[31:16] <= dl.data;
			end
		end
	end

	// Write pulses, one cycle after the high half
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			pif_en     <= 1'b0;
			ram_strobe <= 1'b0;
		end else begin
			pif_en     <= pif_push && dl.addr[1];
			ram_strobe <= cart_push && dl.addr[1];
		end
	end

	assign pif_wr  = '{addr: pif_addr, data: pif_data, en: pif_en};
	assign ram_req = '{addr: ram_addr, data: ram_data, req: ram_strobe};

endmodule

//--- src/loader_fsm.sv
module loader_fsm
	import loader_pkg::*;
(
	input  logic        clk_1x,
	input  logic        arst_n,
	input  dl_in_t      dl,
	input  logic        ram_ready,
	output load_state_t state,
	output logic        cart_download,
	output logic        cart_start,
	output logic        pif_push,
	output logic        cart_push,
	output logic        ioctl_wait
);

	load_state_t state_next;
	logic [5:0]  target;
	logic        high_half;

	// Target is picked by the low six index bits only
	assign target    = dl.index[5:0];
	assign high_half = dl.addr[1];

	// ==================================================
	// Next state
	// ==================================================

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (dl.download && (target == idx_pif)) begin
					state_next = st_pif;
				end else if (dl.download && (target == idx_cart)) begin
					state_next = st_cart;
				end
			end
			st_pif: begin
				if (!dl.download) begin
					state_next = st_idle;
				end
			end
			st_cart: begin
				if (!dl.download) begin
					state_next = st_idle;
				end else if (cart_push && high_half) begin
					// Word complete, hold host until RAM takes it
					state_next = st_cart_wait;
				end
			end
			st_cart_wait: begin
				if (!dl.download) begin
					state_next = st_idle;
				end else if (ram_ready) begin
					state_next = st_cart;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// ==================================================
	// State register
	// ==================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			cart_start <= 1'b0;
		end else begin
			state <= state_next;
			// One cycle high on the first cycle of a new cartridge mode
			cart_start <= (state == st_idle) && (state_next == st_cart);
		end
	end

	// Mode flags and qualified write strobes
	assign cart_download = (state == st_cart) || (state == st_cart_wait);
	assign pif_push      = dl.wr && (state == st_pif);
	assign cart_push     = dl.wr && (state == st_cart);

	// Host is stalled for exactly the time a word sits with the RAM
	assign ioctl_wait = (state == st_cart_wait);

endmodule

//--- src/loader_pkg.sv
package loader_pkg;

	// ==================================================
	// Download targets and RAM layout
	// ==================================================

	// Low six index bits that select a target
	localparam logic [5:0] idx_pif  = 6'd0;
	localparam logic [5:0] idx_cart = 6'd1;

	// Cartridge image base byte address in RAM
	localparam logic [26:0] cart_start = 27'd8388608;

	// ==================================================
	// Vector types
	// ==================================================

	typedef logic [26:0] dl_addr_t;
	typedef logic [15:0] half_t;
	typedef logic [31:0] word_t;
	typedef logic [9:0]  pif_addr_t;
	typedef logic [26:0] ram_addr_t;
	typedef logic [23:0] cart_count_t;

	// Host download port
	typedef struct packed {
		logic       download;
		logic [7:0] index;
		dl_addr_t   addr;
		half_t      data;
		logic       wr;
	} dl_in_t;

	// Boot-ROM write port
	typedef struct packed {
		pif_addr_t addr;
		word_t     data;
		logic      en;
	} pif_wr_t;

	// RAM request port, one word per req pulse
	typedef struct packed {
		ram_addr_t addr;
		word_t     data;
		logic      req;
	} ram_req_t;

	typedef enum logic [1:0] {
		st_idle,
		st_pif,
		st_cart,
		st_cart_wait
	} load_state_t;

endpackage
